/* rtl/bp_pkg.sv */
package bp_pkg;

    // ##################################################
    // state encodings

    typedef enum logic [1:0] {
        FETCH_RUN  = 2'd0,  // fetching
        FETCH_ACK  = 2'd1,  // redirect ack high
        FETCH_HOLD = 2'd2   // waiting out penalty
    } fetch_state_e;

    typedef enum logic [1:0] {
        RETIRE_IDLE  = 2'd0,
        RETIRE_WRITE = 2'd1,  // single write cycle
        RETIRE_ACK   = 2'd2   // wait for req low
    } retire_state_e;

    // ##################################################
    // default parameter values

    localparam int          ADDR_WIDTH_DEF  = 32;
    localparam int          BTB_ENTRIES_DEF = 16;
    localparam int          PENALTY_DEF     = 3;
    localparam logic [31:0] RESET_PC_DEF    = 32'h0000_1000;

endpackage

/* rtl/btb.sv */
`timescale 1ns/10ps

module btb #(
    parameter int ADDR_WIDTH  = bp_pkg::ADDR_WIDTH_DEF,
    parameter int BTB_ENTRIES = bp_pkg::BTB_ENTRIES_DEF
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic [ADDR_WIDTH-1:0] fetch_pc,
    output logic                  predict_taken_0,
    output logic [ADDR_WIDTH-1:0] predict_target_0,
    output logic                  predict_taken_1,
    output logic [ADDR_WIDTH-1:0] predict_target_1,

    input  logic                  wr_en_0,
    input  logic [ADDR_WIDTH-1:0] wr_pc_0,
    input  logic [ADDR_WIDTH-1:0] wr_target_0,
    input  logic                  wr_taken_0,
    input  logic                  wr_en_1,
    input  logic [ADDR_WIDTH-1:0] wr_pc_1,
    input  logic [ADDR_WIDTH-1:0] wr_target_1,
    input  logic                  wr_taken_1
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = ADDR_WIDTH - IDX_W - 2;  // bits above index

    logic                  entry_valid  [BTB_ENTRIES];
    logic                  entry_taken  [BTB_ENTRIES];
    logic [TAG_W-1:0]      entry_tag    [BTB_ENTRIES];
    logic [ADDR_WIDTH-1:0] entry_target [BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx_0;
    logic [IDX_W-1:0] rd_idx_1;
    logic [TAG_W-1:0] rd_tag_0;
    logic [TAG_W-1:0] rd_tag_1;
    logic             hit_0;
    logic             hit_1;

    logic [IDX_W-1:0] wr_idx_0;
    logic [IDX_W-1:0] wr_idx_1;
    logic [TAG_W-1:0] wr_tag_0;
    logic [TAG_W-1:0] wr_tag_1;

    function automatic logic entry_hit(
        input logic             valid,
        input logic             taken,
        input logic [TAG_W-1:0] stored_tag,
        input logic [TAG_W-1:0] lookup_tag
    );
        return valid && taken && (stored_tag == lookup_tag);
    endfunction

    // ##################################################
    // chained lookup

    assign rd_idx_0 = fetch_pc[IDX_W+1:2];
    assign rd_tag_0 = fetch_pc[ADDR_WIDTH-1:IDX_W+2];

    assign hit_0 = entry_hit(entry_valid[rd_idx_0], entry_taken[rd_idx_0],
                             entry_tag[rd_idx_0], rd_tag_0);

    assign predict_taken_0  = hit_0;
    assign predict_target_0 = hit_0 ? entry_target[rd_idx_0]
                                    : fetch_pc + ADDR_WIDTH'(4);

    // slot 1 looks up where slot 0 goes
    assign rd_idx_1 = predict_target_0[IDX_W+1:2];
    assign rd_tag_1 = predict_target_0[ADDR_WIDTH-1:IDX_W+2];

    assign hit_1 = entry_hit(entry_valid[rd_idx_1], entry_taken[rd_idx_1],
                             entry_tag[rd_idx_1], rd_tag_1);

    assign predict_taken_1  = hit_1;
    assign predict_target_1 = hit_1 ? entry_target[rd_idx_1]
                                    : predict_target_0 + ADDR_WIDTH'(4);

    // ##################################################
    // retire writes

    assign wr_idx_0 = wr_pc_0[IDX_W+1:2];
    assign wr_tag_0 = wr_pc_0[ADDR_WIDTH-1:IDX_W+2];
    assign wr_idx_1 = wr_pc_1[IDX_W+1:2];
    assign wr_tag_1 = wr_pc_1[ADDR_WIDTH-1:IDX_W+2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                entry_valid[i]  <= 1'b0;
                entry_taken[i]  <= 1'b0;
                entry_tag[i]    <= '0;
                entry_target[i] <= '0;
            end
        end else begin
            if (wr_en_0) begin
                entry_valid[wr_idx_0]  <= 1'b1;
                entry_taken[wr_idx_0]  <= wr_taken_0;
                entry_tag[wr_idx_0]    <= wr_tag_0;
                entry_target[wr_idx_0] <= wr_target_0;
            end
            if (wr_en_1) begin  // younger slot overrides port 0
                entry_valid[wr_idx_1]  <= 1'b1;
                entry_taken[wr_idx_1]  <= wr_taken_1;
                entry_tag[wr_idx_1]    <= wr_tag_1;
                entry_target[wr_idx_1] <= wr_target_1;
            end
        end
    end

endmodule

/* rtl/retire_port.sv */
`timescale 1ns/10ps

module retire_port #(
    parameter int ADDR_WIDTH = bp_pkg::ADDR_WIDTH_DEF
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  retire_req,
    input  logic                  retire_valid_0,
    input  logic [ADDR_WIDTH-1:0] retire_pc_0,
    input  logic [ADDR_WIDTH-1:0] retire_target_0,
    input  logic                  retire_taken_0,
    input  logic                  retire_valid_1,
    input  logic [ADDR_WIDTH-1:0] retire_pc_1,
    input  logic [ADDR_WIDTH-1:0] retire_target_1,
    input  logic                  retire_taken_1,
    output logic                  retire_ack,

    output logic                  wr_en_0,
    output logic [ADDR_WIDTH-1:0] wr_pc_0,
    output logic [ADDR_WIDTH-1:0] wr_target_0,
    output logic                  wr_taken_0,
    output logic                  wr_en_1,
    output logic [ADDR_WIDTH-1:0] wr_pc_1,
    output logic [ADDR_WIDTH-1:0] wr_target_1,
    output logic                  wr_taken_1
);

    bp_pkg::retire_state_e state;
    bp_pkg::retire_state_e state_next;

    logic valid_0_q;
    logic valid_1_q;

    always_comb begin
        state_next = state;
        case (state)
            bp_pkg::RETIRE_IDLE: begin
                if (retire_req) begin
                    state_next = bp_pkg::RETIRE_WRITE;
                end
            end
            bp_pkg::RETIRE_WRITE: begin
                state_next = bp_pkg::RETIRE_ACK;  // one write only
            end
            bp_pkg::RETIRE_ACK: begin
                if (!retire_req) begin
                    state_next = bp_pkg::RETIRE_IDLE;
                end
            end
            default: state_next = bp_pkg::RETIRE_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= bp_pkg::RETIRE_IDLE;
            retire_ack <= 1'b0;
        end else begin
            state      <= state_next;
            retire_ack <= (state_next == bp_pkg::RETIRE_ACK);  // rises with the write
        end
    end

    // slot capture when the request is first seen
    always_ff @(posedge clk) begin
        if (state == bp_pkg::RETIRE_IDLE && retire_req) begin
            valid_0_q   <= retire_valid_0;
            wr_pc_0     <= retire_pc_0;
            wr_target_0 <= retire_target_0;
            wr_taken_0  <= retire_taken_0;
            valid_1_q   <= retire_valid_1;
            wr_pc_1     <= retire_pc_1;
            wr_target_1 <= retire_target_1;
            wr_taken_1  <= retire_taken_1;
        end
    end

    assign wr_en_0 = (state == bp_pkg::RETIRE_WRITE) && valid_0_q;
    assign wr_en_1 = (state == bp_pkg::RETIRE_WRITE) && valid_1_q;

endmodule

/* rtl/penalty_timer.sv */
`timescale 1ns/10ps

module penalty_timer #(
    parameter int PENALTY = bp_pkg::PENALTY_DEF
) (
    input  logic clk,
    input  logic rst,
    input  logic timer_load,
    output logic timer_done
);

    localparam int CNT_W = (PENALTY > 0) ? $clog2(PENALTY + 1) : 1;

    logic [CNT_W-1:0] count;

    // starts loaded so the first fetch also waits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= CNT_W'(PENALTY);
        end else if (timer_load) begin
            count <= CNT_W'(PENALTY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign timer_done = (count == '0) && !timer_load;  // stale zero hidden by load

endmodule

/* rtl/fetch_ctrl.sv */
`timescale 1ns/10ps

module fetch_ctrl #(
    parameter int                    ADDR_WIDTH = bp_pkg::ADDR_WIDTH_DEF,
    parameter logic [ADDR_WIDTH-1:0] RESET_PC   = ADDR_WIDTH'(bp_pkg::RESET_PC_DEF)
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  fetch_ready,
    input  logic [ADDR_WIDTH-1:0] predict_target_1,
    output logic [ADDR_WIDTH-1:0] fetch_pc,
    output logic                  fetch_valid,

    input  logic                  redirect_req,
    input  logic [ADDR_WIDTH-1:0] redirect_pc,
    output logic                  redirect_ack,

    output logic                  timer_load,
    input  logic                  timer_done
);

    bp_pkg::fetch_state_e  state;
    bp_pkg::fetch_state_e  state_next;
    logic [ADDR_WIDTH-1:0] pc_next;

    // ##################################################
    // next state and next pc

    always_comb begin
        state_next = state;
        pc_next    = fetch_pc;
        timer_load = 1'b0;
        case (state)
            bp_pkg::FETCH_RUN: begin
                if (redirect_req) begin  // drops a held bundle
                    state_next = bp_pkg::FETCH_ACK;
                    pc_next    = redirect_pc;
                end else if (fetch_ready) begin
                    pc_next = predict_target_1;  // bundle accepted
                end
            end
            bp_pkg::FETCH_ACK: begin
                if (!redirect_req) begin
                    state_next = bp_pkg::FETCH_HOLD;
                    timer_load = 1'b1;
                end
            end
            bp_pkg::FETCH_HOLD: begin
                if (redirect_req) begin
                    state_next = bp_pkg::FETCH_ACK;
                    pc_next    = redirect_pc;
                end else if (timer_done) begin
                    state_next = bp_pkg::FETCH_RUN;
                end
            end
            default: state_next = bp_pkg::FETCH_HOLD;
        endcase
    end

    // ##################################################
    // state and pc registers

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= bp_pkg::FETCH_HOLD;  // timer already holds the penalty
            fetch_pc <= RESET_PC;
        end else begin
            state    <= state_next;
            fetch_pc <= pc_next;
        end
    end

    assign redirect_ack = (state == bp_pkg::FETCH_ACK);
    assign fetch_valid  = (state == bp_pkg::FETCH_RUN);

endmodule

/* rtl/bp_front.sv */
`timescale 1ns/10ps

module bp_front #(
    parameter int                    ADDR_WIDTH  = bp_pkg::ADDR_WIDTH_DEF,
    parameter int                    BTB_ENTRIES = bp_pkg::BTB_ENTRIES_DEF,
    parameter int                    PENALTY     = bp_pkg::PENALTY_DEF,
    parameter logic [ADDR_WIDTH-1:0] RESET_PC    = ADDR_WIDTH'(bp_pkg::RESET_PC_DEF)
) (
    input  logic                  clk,
    input  logic                  rst,

    // fetch consumer
    output logic [ADDR_WIDTH-1:0] fetch_pc,
    output logic                  fetch_valid,
    input  logic                  fetch_ready,
    output logic                  predict_taken_0,
    output logic [ADDR_WIDTH-1:0] predict_target_0,
    output logic                  predict_taken_1,
    output logic [ADDR_WIDTH-1:0] predict_target_1,

    // commit redirect
    input  logic                  redirect_req,
    input  logic [ADDR_WIDTH-1:0] redirect_pc,
    output logic                  redirect_ack,

    // commit retire
    input  logic                  retire_req,
    input  logic                  retire_valid_0,
    input  logic [ADDR_WIDTH-1:0] retire_pc_0,
    input  logic [ADDR_WIDTH-1:0] retire_target_0,
    input  logic                  retire_taken_0,
    input  logic                  retire_valid_1,
    input  logic [ADDR_WIDTH-1:0] retire_pc_1,
    input  logic [ADDR_WIDTH-1:0] retire_target_1,
    input  logic                  retire_taken_1,
    output logic                  retire_ack
);

    logic                  timer_load;
    logic                  timer_done;

    logic                  wr_en_0;
    logic [ADDR_WIDTH-1:0] wr_pc_0;
    logic [ADDR_WIDTH-1:0] wr_target_0;
    logic                  wr_taken_0;
    logic                  wr_en_1;
    logic [ADDR_WIDTH-1:0] wr_pc_1;
    logic [ADDR_WIDTH-1:0] wr_target_1;
    logic                  wr_taken_1;

    fetch_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .RESET_PC   (RESET_PC)
    ) fetch_ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .fetch_ready      (fetch_ready),
        .predict_target_1 (predict_target_1),
        .fetch_pc         (fetch_pc),
        .fetch_valid      (fetch_valid),
        .redirect_req     (redirect_req),
        .redirect_pc      (redirect_pc),
        .redirect_ack     (redirect_ack),
        .timer_load       (timer_load),
        .timer_done       (timer_done)
    );

    penalty_timer #(
        .PENALTY (PENALTY)
    ) penalty_timer_i (
        .clk        (clk),
        .rst        (rst),
        .timer_load (timer_load),
        .timer_done (timer_done)
    );

    btb #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) btb_i (
        .clk              (clk),
        .rst              (rst),
        .fetch_pc         (fetch_pc),
        .predict_taken_0  (predict_taken_0),
        .predict_target_0 (predict_target_0),
        .predict_taken_1  (predict_taken_1),
        .predict_target_1 (predict_target_1),
        .wr_en_0          (wr_en_0),
        .wr_pc_0          (wr_pc_0),
        .wr_target_0      (wr_target_0),
        .wr_taken_0       (wr_taken_0),
        .wr_en_1          (wr_en_1),
        .wr_pc_1          (wr_pc_1),
        .wr_target_1      (wr_target_1),
        .wr_taken_1       (wr_taken_1)
    );

    retire_port #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) retire_port_i (
        .clk             (clk),
        .rst             (rst),
        .retire_req      (retire_req),
        .retire_valid_0  (retire_valid_0),
        .retire_pc_0     (retire_pc_0),
        .retire_target_0 (retire_target_0),
        .retire_taken_0  (retire_taken_0),
        .retire_valid_1  (retire_valid_1),
        .retire_pc_1     (retire_pc_1),
        .retire_target_1 (retire_target_1),
        .retire_taken_1  (retire_taken_1),
        .retire_ack      (retire_ack),
        .wr_en_0         (wr_en_0),
        .wr_pc_0         (wr_pc_0),
        .wr_target_0     (wr_target_0),
        .wr_taken_0      (wr_taken_0),
        .wr_en_1         (wr_en_1),
        .wr_pc_1         (wr_pc_1),
        .wr_target_1     (wr_target_1),
        .wr_taken_1      (wr_taken_1)
    );

endmodule

/* bench/bp_front_asserts.sv */
`timescale 1ns/10ps

module bp_front_asserts (
    input logic clk,
    input logic rst,
    input logic retire_req,
    input logic retire_ack,
    input logic redirect_req,
    input logic redirect_ack,
    input logic fetch_valid,
    input logic wr_en_0,
    input logic wr_en_1
);

    int fail_count = 0;

    // ##################################################
    // four-phase handshakes

    retire_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(retire_ack) |-> retire_req)
        else begin
            fail_count++;
            $error("retire_ack rose while retire_req was low");
        end

    retire_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(retire_ack) |-> $past(!retire_req))
        else begin
            fail_count++;
            $error("retire_ack fell before retire_req was seen low");
        end

    redirect_ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(redirect_ack) |-> redirect_req)
        else begin
            fail_count++;
            $error("redirect_ack rose while redirect_req was low");
        end

    redirect_ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(redirect_ack) |-> $past(!redirect_req))
        else begin
            fail_count++;
            $error("redirect_ack fell before redirect_req was seen low");
        end

    // ##################################################
    // fetch hold and write strobes

    valid_low_in_ack: assert property (@(posedge clk) disable iff (rst)
        (redirect_req || redirect_ack) |=> !fetch_valid)
        else begin
            fail_count++;
            $error("fetch_valid high during a redirect handshake");
        end

    single_write: assert property (@(posedge clk) disable iff (rst)
        (wr_en_0 || wr_en_1) |=> !(wr_en_0 || wr_en_1))
        else begin
            fail_count++;
            $error("table write strobe high on two cycles in a row");
        end

endmodule

bind bp_front bp_front_asserts bp_front_asserts_i (
    .clk          (clk),
    .rst          (rst),
    .retire_req   (retire_req),
    .retire_ack   (retire_ack),
    .redirect_req (redirect_req),
    .redirect_ack (redirect_ack),
    .fetch_valid  (fetch_valid),
    .wr_en_0      (wr_en_0),
    .wr_en_1      (wr_en_1)
);

/* bench/bp_front_tb.sv */
`timescale 1ns/10ps

module bp_front_tb;

    localparam int                    ADDR_WIDTH     = bp_pkg::ADDR_WIDTH_DEF;
    localparam int                    BTB_ENTRIES    = bp_pkg::BTB_ENTRIES_DEF;
    localparam int                    PENALTY        = bp_pkg::PENALTY_DEF;
    localparam logic [ADDR_WIDTH-1:0] RESET_PC       = bp_pkg::RESET_PC_DEF;
    localparam int                    IDX_W          = $clog2(BTB_ENTRIES);
    localparam int                    NUM_OPS        = 400;
    localparam int                    POOL_SIZE      = 12;
    localparam int                    TIMEOUT_CYCLES = NUM_OPS * (PENALTY + 12) + 200;
    localparam logic [31:0]           SEED           = 32'h0d69_c884;

    logic                  clk;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] fetch_pc;
    logic                  fetch_valid;
    logic                  fetch_ready;
    logic                  predict_taken_0;
    logic [ADDR_WIDTH-1:0] predict_target_0;
    logic                  predict_taken_1;
    logic [ADDR_WIDTH-1:0] predict_target_1;
    logic                  redirect_req;
    logic [ADDR_WIDTH-1:0] redirect_pc;
    logic                  redirect_ack;
    logic                  retire_req;
    logic                  retire_valid_0;
    logic [ADDR_WIDTH-1:0] retire_pc_0;
    logic [ADDR_WIDTH-1:0] retire_target_0;
    logic                  retire_taken_0;
    logic                  retire_valid_1;
    logic [ADDR_WIDTH-1:0] retire_pc_1;
    logic [ADDR_WIDTH-1:0] retire_target_1;
    logic                  retire_taken_1;
    logic                  retire_ack;

    // reference table
    logic                  m_valid  [BTB_ENTRIES];
    logic                  m_taken  [BTB_ENTRIES];
    logic [ADDR_WIDTH-1:0] m_tag    [BTB_ENTRIES];
    logic [ADDR_WIDTH-1:0] m_target [BTB_ENTRIES];

    logic [ADDR_WIDTH-1:0] pool [POOL_SIZE];
    int                    checks;
    int                    errors;

    bp_front dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ##################################################
    // model and checking helpers

    function automatic int unsigned index_of(input logic [ADDR_WIDTH-1:0] pc);
        return (pc >> 2) % BTB_ENTRIES;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] tag_of(input logic [ADDR_WIDTH-1:0] pc);
        return pc >> (IDX_W + 2);  // everything above the index
    endfunction

    task automatic model_lookup(input logic [ADDR_WIDTH-1:0] pc, output logic taken,
                                output logic [ADDR_WIDTH-1:0] target);
        int unsigned idx;
        idx    = index_of(pc);
        taken  = m_valid[idx] && m_taken[idx] && (m_tag[idx] == tag_of(pc));
        target = taken ? m_target[idx] : pc + 4;
    endtask

    task automatic model_write(input logic [ADDR_WIDTH-1:0] pc,
                               input logic [ADDR_WIDTH-1:0] target, input logic taken);
        int unsigned idx;
        idx           = index_of(pc);
        m_valid[idx]  = 1'b1;
        m_taken[idx]  = taken;
        m_tag[idx]    = tag_of(pc);
        m_target[idx] = target;
    endtask

    task automatic check_value(input string name, input logic [ADDR_WIDTH-1:0] expected,
                               input logic [ADDR_WIDTH-1:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic logic [ADDR_WIDTH-1:0] pick_pc();
        return pool[$urandom % POOL_SIZE];
    endfunction

    // ##################################################
    // per-cycle prediction monitor

    always @(negedge clk) begin : monitor
        logic                  exp_taken_0;
        logic                  exp_taken_1;
        logic [ADDR_WIDTH-1:0] exp_target_0;
        logic [ADDR_WIDTH-1:0] exp_target_1;
        logic                  wrote;
        static logic                  prev_ack       = 1'b0;
        static logic                  accept_pending = 1'b0;
        static logic                  hold_pending   = 1'b0;
        static logic [ADDR_WIDTH-1:0] next_pc        = '0;
        static logic [ADDR_WIDTH-1:0] held_pc        = '0;
        static logic [ADDR_WIDTH-1:0] held_target_0  = '0;
        static logic [ADDR_WIDTH-1:0] held_target_1  = '0;
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                m_valid[i] = 1'b0;
                m_taken[i] = 1'b0;
            end
            prev_ack       = 1'b0;
            accept_pending = 1'b0;
            hold_pending   = 1'b0;
        end else begin
            wrote = retire_ack && !prev_ack;  // table written on the ack edge
            if (wrote) begin
                if (retire_valid_0) model_write(retire_pc_0, retire_target_0, retire_taken_0);
                if (retire_valid_1) model_write(retire_pc_1, retire_target_1, retire_taken_1);
            end
            prev_ack = retire_ack;
            if (accept_pending) check_value("accept_next_pc", next_pc, fetch_pc);
            if (hold_pending) begin
                check_value("hold_fetch_pc", held_pc, fetch_pc);
                if (!wrote) begin
                    check_value("hold_target_0", held_target_0, predict_target_0);
                    check_value("hold_target_1", held_target_1, predict_target_1);
                end
            end
            if (fetch_valid) begin
                model_lookup(fetch_pc, exp_taken_0, exp_target_0);
                model_lookup(exp_target_0, exp_taken_1, exp_target_1);  // chained
                check_value("slot0_taken", exp_taken_0, predict_taken_0);
                check_value("slot0_target", exp_target_0, predict_target_0);
                check_value("slot1_taken", exp_taken_1, predict_taken_1);
                check_value("slot1_target", exp_target_1, predict_target_1);
            end
            accept_pending = fetch_valid && fetch_ready && !redirect_req;
            hold_pending   = fetch_valid && !fetch_ready && !redirect_req;
            next_pc        = exp_target_1;
            held_pc        = fetch_pc;
            held_target_0  = exp_target_0;
            held_target_1  = exp_target_1;
        end
    end

    // ##################################################
    // stimulus tasks

    task automatic next_edge();
        @(posedge clk);
        fetch_ready <= ($urandom % 4) != 0;
    endtask

    task automatic check_reset_release();
        int edges;
        repeat (16) next_edge();
        rst   <= 1'b0;
        edges = 0;
        do begin
            next_edge();
            edges++;
            @(negedge clk);
        end while (!fetch_valid);
        check_value("reset_valid_delay", PENALTY + 1, edges);
        check_value("reset_fetch_pc", RESET_PC, fetch_pc);
        check_value("reset_taken_0", 1'b0, predict_taken_0);
        check_value("reset_target_0", RESET_PC + 4, predict_target_0);
        check_value("reset_taken_1", 1'b0, predict_taken_1);
        check_value("reset_target_1", RESET_PC + 8, predict_target_1);
    endtask

    task automatic run_retire();
        logic [ADDR_WIDTH-1:0] pc_0;
        int                    edges;
        pc_0 = pick_pc();
        next_edge();
        retire_req      <= 1'b1;
        retire_valid_0  <= ($urandom % 4) != 0;
        retire_pc_0     <= pc_0;
        retire_target_0 <= pick_pc();
        retire_taken_0  <= ($urandom % 4) != 0;
        retire_valid_1  <= ($urandom % 4) != 0;
        retire_pc_1     <= (($urandom % 4) == 0) ? pc_0 : pick_pc();  // forced same index
        retire_target_1 <= pick_pc();
        retire_taken_1  <= ($urandom % 4) != 0;
        edges = 0;
        do begin
            next_edge();
            edges++;
            @(negedge clk);
        end while (!retire_ack);
        check_value("retire_ack_rise", 2, edges);
        next_edge();
        retire_req <= 1'b0;
        edges      = 0;
        do begin
            next_edge();
            edges++;
            @(negedge clk);
        end while (retire_ack);
        check_value("retire_ack_fall", 1, edges);
    endtask

    task automatic run_redirect();
        logic [ADDR_WIDTH-1:0] target;
        int                    edges;
        int                    ack_fall;
        target = pick_pc();
        next_edge();
        redirect_req <= 1'b1;
        redirect_pc  <= target;
        edges        = 0;
        do begin
            next_edge();
            edges++;
            @(negedge clk);
        end while (!redirect_ack);
        check_value("redirect_ack_rise", 1, edges);
        check_value("redirect_valid_in_ack", 1'b0, fetch_valid);
        next_edge();
        redirect_req <= 1'b0;
        edges        = 0;
        ack_fall     = 0;
        do begin
            next_edge();
            edges++;
            @(negedge clk);
            if (!redirect_ack && ack_fall == 0) ack_fall = edges;
        end while (!fetch_valid);
        check_value("redirect_ack_fall", 1, ack_fall);
        check_value("redirect_resume", PENALTY + 2, edges);
        check_value("redirect_fetch_pc", target, fetch_pc);
    endtask

    task automatic run_idle();
        repeat (1 + $urandom % 4) begin
            next_edge();
            @(negedge clk);
        end
    endtask

    // ##################################################
    // main sequence

    initial begin : stimulus
        int unsigned op;
        int          failures;
        void'($urandom(SEED));
        checks          = 0;
        errors          = 0;
        rst             = 1'b1;
        fetch_ready     = 1'b0;
        redirect_req    = 1'b0;
        redirect_pc     = '0;
        retire_req      = 1'b0;
        retire_valid_0  = 1'b0;
        retire_pc_0     = '0;
        retire_target_0 = '0;
        retire_taken_0  = 1'b0;
        retire_valid_1  = 1'b0;
        retire_pc_1     = '0;
        retire_target_1 = '0;
        retire_taken_1  = 1'b0;
        // two tags over eight indexes near the reset pc
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = RESET_PC + (($urandom % 2) << (IDX_W + 2)) + (($urandom % 8) << 2);
        end
        check_reset_release();
        for (int i = 0; i < NUM_OPS; i++) begin
            op = $urandom % 8;
            if (op < 4) begin
                run_retire();
            end else if (op < 6) begin
                run_redirect();
            end else begin
                run_idle();
            end
        end
        run_idle();
        failures = errors + dut_i.bp_front_asserts_i.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut_i.bp_front_asserts_i.fail_count);
        if (failures == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* bp_front.f */
rtl/bp_pkg.sv
rtl/btb.sv
rtl/retire_port.sv
rtl/penalty_timer.sv
rtl/fetch_ctrl.sv
rtl/bp_front.sv
bench/bp_front_asserts.sv
bench/bp_front_tb.sv
